// ==== hw/captureDefines.svh ====
`ifndef CAPTURE_DEFINES_SVH
`define CAPTURE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line buffer geometry.
`define RAM_ADDRESS_BITS    14
`define BUFFER_LINE_LENGTH  640
`define BUFFER_SIZE         16
`define TRIGGER_ADDR        5120    // Start of buffer line 8.
`define READ_LENGTH         5120

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Capture windows. Both modes start at row 0.
`define H_START_P           44
`define H_END_P             684
`define V_END_P             480
`define H_START_D           1
`define H_END_D             641
`define V_END_D             504
`define GAP_START_D         240
`define GAP_END_D           263     // First row after the gap.

`endif

// ==== hw/capturePkg.sv ====
`default_nettype none

`include "captureDefines.svh"

package capturePkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixelT;

    // Incoming stream of one pixel per clock.
    typedef struct packed {
        pixelT pixel;
        logic  hSync;   // First pixel of a line.
        logic  vSync;   // First line of a frame.
    } videoInT;

    typedef struct packed {
        pixelT       pixel;
        logic [11:0] x;
        logic [11:0] y;
    } rasterT;

    typedef struct packed {
        logic                         enable;
        logic [`RAM_ADDRESS_BITS-1:0] addr;
        pixelT                        data;
    } ramWriteT;

    typedef struct packed {
        logic  valid;
        logic  first;   // First word of a readout.
        pixelT pixel;
    } readOutT;

endpackage

`default_nettype wire

// ==== hw/rasterCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rasterCounter (
    input  wire logic               clock,
    input  wire logic               rstN,
    input  wire capturePkg::videoInT videoIn,
    output capturePkg::rasterT      raster
);

    import capturePkg::*;

    logic [11:0] xCount;
    logic [11:0] yCount;
    logic [11:0] nextX;
    logic [11:0] nextY;
    pixelT       pixelReg;

    // Position of the pixel now on the input.
    always_comb begin
        if (videoIn.hSync) begin
            nextX = '0;
            nextY = videoIn.vSync ? '0 : yCount + 12'd1;
        end else begin
            nextX = xCount + 12'd1;
            nextY = yCount;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            xCount <= '0;
            yCount <= '0;
        end else begin
            xCount <= nextX;
            yCount <= nextY;
        end
    end

    always_ff @(posedge clock) begin
        pixelReg <= videoIn.pixel;   // Travels with its position.
    end

    assign raster = '{pixel: pixelReg, x: xCount, y: yCount};

    // Frame start only ever marks a line start.
    vSyncOnLineStart: assert property (
        @(posedge clock) disable iff (!rstN)
        videoIn.vSync |-> videoIn.hSync
    );

endmodule

`default_nettype wire

// ==== hw/captureControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "captureDefines.svh"

module captureControl (
    input  wire logic              clock,
    input  wire logic              rstN,
    input  wire capturePkg::rasterT raster,
    input  wire logic              lineDoubler,
    output capturePkg::ramWriteT   ramWrite,
    output logic                   startTrigger
);

    import capturePkg::*;

    logic [11:0] hStart;
    logic [11:0] hEnd;
    logic        inWindowX;
    logic        rowActive;
    logic        writeHit;
    logic        addrLoad;
    logic        triggerHit;

    logic [`RAM_ADDRESS_BITS-1:0] lineBase;
    logic [`RAM_ADDRESS_BITS-1:0] colOffset;
    logic [`RAM_ADDRESS_BITS-1:0] pixelAddr;

    logic                         writeEnable;
    logic [`RAM_ADDRESS_BITS-1:0] writeAddr;
    pixelT                        writeData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Window decode

    always_comb begin
        if (lineDoubler) begin
            hStart = 12'(`H_START_D);
            hEnd   = 12'(`H_END_D);
        end else begin
            hStart = 12'(`H_START_P);
            hEnd   = 12'(`H_END_P);
        end
    end

    assign inWindowX = (raster.x >= hStart) && (raster.x < hEnd);

    // Line-doubled frames skip the rows between the two fields.
    always_comb begin
        if (lineDoubler) begin
            rowActive = (raster.y < `GAP_START_D) ||
                        ((raster.y >= `GAP_END_D) && (raster.y < `V_END_D));
        end else begin
            rowActive = raster.y < `V_END_P;
        end
    end

    assign writeHit = inWindowX && rowActive;

    // Doubled mode tracks the address over every window column.
    assign addrLoad = lineDoubler ? inWindowX : writeHit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address generation

    assign lineBase  = `RAM_ADDRESS_BITS'((raster.y % `BUFFER_SIZE) * `BUFFER_LINE_LENGTH);
    assign colOffset = `RAM_ADDRESS_BITS'(raster.x - hStart);
    assign pixelAddr = lineBase + colOffset;   // Wraps every BUFFER_SIZE lines.

    // Fires once per frame when the first half of the buffer is full.
    assign triggerHit = inWindowX && (raster.y < `BUFFER_SIZE) &&
                        (pixelAddr == `RAM_ADDRESS_BITS'(`TRIGGER_ADDR));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output registers

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            writeEnable  <= 1'b0;
            startTrigger <= 1'b0;
        end else begin
            writeEnable  <= writeHit;
            startTrigger <= triggerHit;
        end
    end

    always_ff @(posedge clock) begin
        if (addrLoad) begin
            writeAddr <= pixelAddr;
        end
        if (writeHit) begin
            writeData <= raster.pixel;
        end
    end

    assign ramWrite = '{enable: writeEnable, addr: writeAddr, data: writeData};

    // Trigger word is always one that lands in the buffer.
    triggerWithWrite: assert property (
        @(posedge clock) disable iff (!rstN)
        startTrigger |-> ramWrite.enable
    );

endmodule

`default_nettype wire

// ==== hw/lineBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "captureDefines.svh"

module lineBuffer (
    input  wire logic                         clock,
    input  wire capturePkg::ramWriteT         ramWrite,
    input  wire logic [`RAM_ADDRESS_BITS-1:0] readAddr,
    output capturePkg::pixelT                 readData
);

    import capturePkg::*;

    localparam int Depth = `BUFFER_SIZE * `BUFFER_LINE_LENGTH;

    pixelT mem [Depth];

    always_ff @(posedge clock) begin
        if (ramWrite.enable) begin
            mem[ramWrite.addr] <= ramWrite.data;
        end
    end

    // Registered read with one cycle of latency.
    always_ff @(posedge clock) begin
        readData <= mem[readAddr];
    end

    // Capture side never addresses past the last line.
    writeInBuffer: assert property (
        @(posedge clock)
        ramWrite.enable |-> (ramWrite.addr < Depth)
    );

endmodule

`default_nettype wire

// ==== hw/bufferReader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "captureDefines.svh"

module bufferReader (
    input  wire logic                   clock,
    input  wire logic                   rstN,
    input  wire logic                   startTrigger,
    input  wire capturePkg::pixelT      readData,
    output logic [`RAM_ADDRESS_BITS-1:0] readAddr,
    output capturePkg::readOutT         readOut
);

    logic busy;
    logic lastAddr;
    logic validDelay;
    logic firstDelay;

    assign lastAddr = readAddr == `RAM_ADDRESS_BITS'(`READ_LENGTH - 1);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            busy     <= 1'b0;
            readAddr <= '0;
        end else if (startTrigger) begin
            busy     <= 1'b1;
            readAddr <= '0;
        end else if (busy) begin
            if (lastAddr) begin
                busy     <= 1'b0;
                readAddr <= '0;   // Park at the start.
            end else begin
                readAddr <= readAddr + 1'b1;
            end
        end
    end

    // Flags follow the memory latency.
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            validDelay <= 1'b0;
            firstDelay <= 1'b0;
        end else begin
            validDelay <= busy;
            firstDelay <= busy && (readAddr == '0);
        end
    end

    assign readOut = '{valid: validDelay, first: firstDelay, pixel: readData};

    // A readout ends long before the next frame's trigger.
    noTriggerWhileBusy: assert property (
        @(posedge clock) disable iff (!rstN)
        startTrigger |-> !busy
    );

endmodule

`default_nettype wire

// ==== hw/videoCaptureTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "captureDefines.svh"

module videoCaptureTop (
    input  wire logic                clock,
    input  wire logic                rstN,
    input  wire capturePkg::videoInT videoIn,
    input  wire logic                lineDoubler,
    output capturePkg::ramWriteT     ramWrite,
    output logic                     startTrigger,
    output capturePkg::readOutT      readOut
);

    import capturePkg::*;

    rasterT                       raster;
    pixelT                        readData;
    logic [`RAM_ADDRESS_BITS-1:0] readAddr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Capture path

    rasterCounter uRasterCounter (
        .clock   (clock),
        .rstN    (rstN),
        .videoIn (videoIn),
        .raster  (raster)
    );

    captureControl uCaptureControl (
        .clock        (clock),
        .rstN         (rstN),
        .raster       (raster),
        .lineDoubler  (lineDoubler),
        .ramWrite     (ramWrite),       // Also leaves the top level.
        .startTrigger (startTrigger)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Buffer and playback

    lineBuffer uLineBuffer (
        .clock    (clock),
        .ramWrite (ramWrite),
        .readAddr (readAddr),
        .readData (readData)
    );

    bufferReader uBufferReader (
        .clock        (clock),
        .rstN         (rstN),
        .startTrigger (startTrigger),
        .readData     (readData),
        .readAddr     (readAddr),
        .readOut      (readOut)
    );

endmodule

`default_nettype wire

// ==== testbench/videoCaptureTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "captureDefines.svh"

module videoCaptureTb;

    import capturePkg::*;

    localparam int MaxFrames     = 32;
    localparam int MaxRows       = 16;
    localparam int LinesPerFrame = 525;
    localparam int PixelsPerLine = 800;

    // Expected response to one input pixel.
    typedef struct packed {
        ramWriteT write;
        logic     trigger;
        int       frameNo;
    } expectT;

    logic     clock = 1'b0;
    logic     rstN;
    videoInT  videoIn;
    logic     lineDoubler;
    ramWriteT ramWrite;
    logic     startTrigger;
    readOutT  readOut;

    logic [31:0] patternWords [MaxRows * 4];
    logic        frameMode [MaxFrames];
    logic [7:0]  frameSeed [MaxFrames];
    int          frameWrites [MaxFrames];
    int          totalFrames;
    longint      watchdogNs = 0;

    expectT expectQ [$];
    int     posX;
    int     posY;
    int     cycle = 0;
    int     countFrame = -1;
    int     writeCount = 0;
    int     readStart = -1000000;   // No readout pending.
    int     readFrame = 0;

    videoCaptureTop dut (
        .clock        (clock),
        .rstN         (rstN),
        .videoIn      (videoIn),
        .lineDoubler  (lineDoubler),
        .ramWrite     (ramWrite),
        .startTrigger (startTrigger),
        .readOut      (readOut)
    );

    always #4 clock = ~clock;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference rules

    function automatic pixelT rulePixel(input int x, input int y, input logic [7:0] seed);
        logic [11:0] px;
        logic [11:0] py;
        pixelT       p;
        px = 12'(x);
        py = 12'(y);
        p.r = px[7:0] ^ seed;
        p.g = py[7:0] + seed;
        p.b = {px[11:8], py[11:8]};
        return p;
    endfunction

    function automatic int windowStart(input logic mode);
        return mode ? `H_START_D : `H_START_P;
    endfunction

    function automatic expectT expectedFor(input int x, input int y, input logic mode,
                                           input pixelT pixel, input int frameNo);
        int     hStart;
        int     hEnd;
        logic   rowOk;
        expectT e;
        hStart = windowStart(mode);
        hEnd   = mode ? `H_END_D : `H_END_P;
        if (mode) begin
            rowOk = (y < `GAP_START_D) || ((y >= `GAP_END_D) && (y < `V_END_D));
        end else begin
            rowOk = y < `V_END_P;
        end
        e.write.enable = (x >= hStart) && (x < hEnd) && rowOk;
        e.write.addr   = `RAM_ADDRESS_BITS'((y % `BUFFER_SIZE) * `BUFFER_LINE_LENGTH
                                            + x - hStart);
        e.write.data   = pixel;
        e.trigger      = (y == 8) && (x == hStart);   // Buffer line 8, column 0.
        e.frameNo      = frameNo;
        return e;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAIL at %0t: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    task automatic checkWrite(input string name, input ramWriteT actual, input ramWriteT expected);
        if (actual.enable !== expected.enable) begin
            abortRun($sformatf("FAIL at %0t: %s.enable is %b, expected %b",
                               $time, name, actual.enable, expected.enable));
        end else if (expected.enable && (actual.addr !== expected.addr)) begin
            abortRun($sformatf("FAIL at %0t: %s.addr is %0d, expected %0d",
                               $time, name, actual.addr, expected.addr));
        end else if (expected.enable && (actual.data !== expected.data)) begin
            abortRun($sformatf("FAIL at %0t: %s.data is %h, expected %h",
                               $time, name, actual.data, expected.data));
        end
    endtask

    task automatic checkPixel(input string name, input pixelT actual, input pixelT expected);
        if (actual !== expected) begin
            abortRun($sformatf("FAIL at %0t: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected) begin
            abortRun($sformatf("FAIL at %0t: %s is %0d, expected %0d",
                               $time, name, actual, expected));
        end
    endtask

    task automatic closeFrame();
        if (countFrame >= 0) begin
            checkCount($sformatf("writes in frame %0d", countFrame), writeCount,
                       frameWrites[countFrame]);
        end
        writeCount = 0;
    endtask

    task automatic checkOutputs(input expectT e);
        int   k;
        logic expValid;
        if (e.frameNo != countFrame) begin
            closeFrame();
            countFrame = e.frameNo;
        end
        checkWrite("ramWrite", ramWrite, e.write);
        checkFlag("startTrigger", startTrigger, e.trigger);
        if (ramWrite.enable) writeCount++;
        if (e.trigger) begin
            readStart = cycle + 2;
            readFrame = e.frameNo;
        end
        k        = cycle - readStart;
        expValid = (k >= 0) && (k < `READ_LENGTH);
        checkFlag("readOut.valid", readOut.valid, expValid);
        checkFlag("readOut.first", readOut.first, expValid && (k == 0));
        if (expValid) begin
            checkPixel("readOut.pixel", readOut.pixel,
                       rulePixel(k % `BUFFER_LINE_LENGTH + windowStart(frameMode[readFrame]),
                                 k / `BUFFER_LINE_LENGTH, frameSeed[readFrame]));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus

    // Drives one pixel and checks the response to an earlier one.
    task automatic runCycle(input videoInT v, input logic mode, input int frameNo);
        expectT e;
        if (v.hSync) begin
            posX = 0;
            posY = v.vSync ? 0 : posY + 1;
        end else begin
            posX = posX + 1;
        end
        videoIn     = v;
        lineDoubler = mode;
        expectQ.push_back(expectedFor(posX, posY, mode, v.pixel, frameNo));
        @(posedge clock);
        #1;
        cycle++;
        e = expectQ.pop_front();
        checkOutputs(e);
    endtask

    task automatic sendFrame(input int frameNo);
        videoInT v;
        for (int line = 0; line < LinesPerFrame; line++) begin
            for (int col = 0; col < PixelsPerLine; col++) begin
                v.pixel = rulePixel(col, line, frameSeed[frameNo]);
                v.hSync = col == 0;
                v.vSync = (col == 0) && (line == 0);
                runCycle(v, frameMode[frameNo], frameNo);
            end
        end
    endtask

    task automatic loadPatterns();
        logic done;
        foreach (patternWords[i]) patternWords[i] = '1;
        $readmemh("testbench/capturePatterns.txt", patternWords);
        totalFrames = 0;
        done        = 1'b0;
        for (int row = 0; row < MaxRows && !done; row++) begin
            if (patternWords[row * 4] > 1) begin
                done = 1'b1;   // End of list.
            end else begin
                for (int n = 0; n < int'(patternWords[row * 4 + 2]); n++) begin
                    if (totalFrames < MaxFrames) begin
                        frameMode[totalFrames]   = patternWords[row * 4][0];
                        frameSeed[totalFrames]   = patternWords[row * 4 + 1][7:0];
                        frameWrites[totalFrames] = int'(patternWords[row * 4 + 3]);
                        totalFrames++;
                    end else begin
                        abortRun("pattern file asks for more frames than the testbench holds");
                    end
                end
            end
        end
        if (totalFrames == 0) abortRun("pattern file holds no frames to run");
    endtask

    initial begin
        int     gap;
        expectT idle;
        rstN        = 1'b0;
        videoIn     = '0;
        lineDoubler = 1'b0;
        posX        = 0;
        posY        = 0;
        void'($urandom(72));
        loadPatterns();
        watchdogNs  = (longint'(totalFrames) * LinesPerFrame * PixelsPerLine + 50000) * 8;
        lineDoubler = frameMode[0];
        repeat (3) @(posedge clock);
        #1;
        checkFlag("ramWrite.enable", ramWrite.enable, 1'b0);
        checkFlag("startTrigger", startTrigger, 1'b0);
        checkFlag("readOut.valid", readOut.valid, 1'b0);
        checkFlag("readOut.first", readOut.first, 1'b0);
        rstN         = 1'b1;
        idle         = '0;
        idle.frameNo = -1;
        expectQ.push_back(idle);
        for (int f = 0; f < totalFrames; f++) begin
            if (f > 0) begin
                gap = int'($urandom % 4);   // Idle cycles before vSync.
                repeat (gap) runCycle('0, frameMode[f - 1], f - 1);
            end
            sendFrame(f);
        end
        repeat (4) runCycle('0, frameMode[totalFrames - 1], totalFrames - 1);
        closeFrame();
        $display("Testbench passed");
        $finish;
    end

    initial begin
        wait (watchdogNs > 0);
        #(watchdogNs);
        abortRun("watchdog expired before all frames were sent and checked");
    end

endmodule

`default_nettype wire

// ==== testbench/capturePatterns.txt ====
// Columns: mode (0 = 480p, 1 = line-doubled), seed, frame count, writes per frame.
// All values hex. A mode above 1 ends the list.

// 480p, two frames back to back.
0 2a 2 4b000

// Line-doubled, gap rows 240 to 262 skipped.
1 5c 2 4b280

// Single frames, the mode flips on every row.
0 00 1 4b000
1 ff 1 4b280
0 91 1 4b000

ff 0 0 0

// ==== list.f ====
+incdir+hw
hw/capturePkg.sv
hw/rasterCounter.sv
hw/captureControl.sv
hw/lineBuffer.sv
hw/bufferReader.sv
hw/videoCaptureTop.sv
testbench/videoCaptureTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module videoCaptureTb

output=$(./obj_dir/VvideoCaptureTb || true)
printf '%s\n' "$output"

# Fails the script when the pass message is missing.
printf '%s\n' "$output" | grep "Testbench passed" > /dev/null
